// ==== Makefile ====
TOP := csr_unit_tb

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -Mdir obj_dir

# Exit status is nonzero when the testbench stops with $fatal
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== dv/csr_unit_assertions.sv ====
`timescale 1ns/100ps

module csr_unit_assertions
    import csr_pkg::*;
(
    input logic      i_clock,
    input logic      i_reset,
    input logic      i_access,
    input logic      i_trap,
    input logic      i_illegal,
    input logic      i_irq_enable,
    input csr_data_t i_mtvec
);

    // ----------------------------------------
    // Access and trap checks
    // ----------------------------------------

    illegal_needs_access : assert property (
        @(posedge i_clock) disable iff (i_reset) i_illegal |-> i_access
    ) else $error("o_illegal raised without i_access");

    // Handler always starts with interrupts off
    trap_masks_irq : assert property (
        @(posedge i_clock) disable iff (i_reset) i_trap |=> !i_irq_enable
    ) else $error("o_irq_enable still high after trap entry");

    mtvec_aligned : assert property (
        @(posedge i_clock) i_mtvec[1:0] == 2'b00   // Direct mode, word aligned
    ) else $error("mtvec low bits not zero");

endmodule

bind csr_unit csr_unit_assertions checks (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_access     (i_access),
    .i_trap       (i_trap),
    .i_illegal    (o_illegal),
    .i_irq_enable (o_irq_enable),
    .i_mtvec      (o_mtvec)
);

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/100ps

module csr_unit_tb
    import csr_pkg::*;
();

    localparam csr_data_t TB_HART_ID   = 32'h0000_0003;
    localparam            VECTOR_FILE  = "dv/csr_unit_vectors.txt";
    localparam [63:0]     TIME_START   = 64'h0000_0002_FFFF_FFF0;   // Low half wraps early
    localparam [63:0]     TIME_STEP    = 64'd5;

    // DUT signals
    logic        clock;
    logic        reset;
    logic        access;
    logic        write_enable;
    csr_op_e     write_mode;
    csr_addr_e   address;
    csr_data_t   write_data;
    logic        trap;
    logic        mret;
    csr_data_t   trap_pc;
    csr_data_t   trap_cause;
    logic [2:0]  irq_pending;
    logic        retire;
    logic [63:0] timer_value;
    csr_data_t   read_data;
    logic        illegal;
    csr_data_t   mepc;
    csr_data_t   mtvec;
    logic        irq_enable;
    logic        irq_request;

    // Vectors, one entry per line of the file
    string       kinds[$];
    logic [11:0] addrs[$];
    csr_data_t   datas[$];
    csr_data_t   extras[$];              // Trap pc or retire flag
    csr_data_t   expects[$];
    logic        illegals[$];

    // Reference model state
    logic        mie_bit     = 1'b0;     // mstatus.MIE
    logic        mpie_bit    = 1'b0;     // mstatus.MPIE
    csr_data_t   mie_reg     = '0;
    csr_data_t   mtvec_reg   = '0;
    csr_data_t   mepc_reg    = '0;       // Aligned return address
    logic [63:0] retire_count = '0;      // Retire pulses already sampled
    logic [63:0] time_expect  = '0;      // Timer value seen at the last edge
    int          seed        = 99;
    int          cycle_count = 0;
    int          cycle_limit = 1000;     // Replaced once the vectors are loaded

    csr_unit #(
        .HART_ID (TB_HART_ID)
    ) uut (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_access       (access),
        .i_write_enable (write_enable),
        .i_write_mode   (write_mode),
        .i_address      (address),
        .i_write_data   (write_data),
        .i_trap         (trap),
        .i_mret         (mret),
        .i_trap_pc      (trap_pc),
        .i_trap_cause   (trap_cause),
        .i_irq_pending  (irq_pending),
        .i_retire       (retire),
        .i_time         (timer_value),
        .o_read_data    (read_data),
        .o_illegal      (illegal),
        .o_mepc         (mepc),
        .o_mtvec        (mtvec),
        .o_irq_enable   (irq_enable),
        .o_irq_request  (irq_request)
    );

    always #2 clock = ~clock;            // 4 ns period

    // Run limit
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("Test failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic check_data(input string what, input csr_data_t got, input csr_data_t want);
        if (got !== want) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("Test failed");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
            $display("Test failed");
            $fatal(1, "Flag mismatch");
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Pending lines sit on the same bit as their enable in mie
    function automatic csr_data_t mip_value(input logic [2:0] pending);
        csr_data_t value;
        value                = '0;
        value[IRQ_SOFT_BIT]  = pending[0];
        value[IRQ_TIMER_BIT] = pending[1];
        value[IRQ_EXT_BIT]   = pending[2];
        return value;
    endfunction

    function automatic csr_data_t merge_write(input string kind, input csr_data_t old,
                                              input csr_data_t data);
        case (kind)
            "set"   : return old | data;
            "clear" : return old & ~data;
            default : return data;
        endcase
    endfunction

    // Counters and mip come from the model, everything else from the file
    function automatic csr_data_t expected_read(input int idx);
        logic [63:0] cycles;
        cycles = 64'(idx);                   // One vector per cycle since reset
        case (addrs[idx])
            12'hC00 : return cycles[31:0];
            12'hC80 : return cycles[63:32];
            12'hC01 : return time_expect[31:0];
            12'hC81 : return time_expect[63:32];
            12'hC02 : return retire_count[31:0];
            12'hC82 : return retire_count[63:32];
            12'h344 : return mip_value(irq_pending);
            default : return expects[idx];
        endcase
    endfunction

    task automatic apply_vector(input int idx);
        access       = 1'b0;
        write_enable = 1'b0;
        write_mode   = CSR_WRITE;
        trap         = 1'b0;
        mret         = 1'b0;
        trap_pc      = '0;
        trap_cause   = '0;
        address      = csr_addr_e'(addrs[idx]);
        write_data   = datas[idx];
        retire       = extras[idx][0];
        case (kinds[idx])
            "read"  : access = 1'b1;
            "write", "set", "clear" : begin
                access       = 1'b1;
                write_enable = 1'b1;
                if (kinds[idx] == "set")
                    write_mode = CSR_SET;
                else if (kinds[idx] == "clear")
                    write_mode = CSR_CLEAR;
            end
            "trap"  : begin
                trap         = 1'b1;
                trap_pc      = extras[idx];
                trap_cause   = datas[idx];
                retire       = 1'b0;
                access       = (addrs[idx] != 12'h000);   // Colliding CSR write
                write_enable = access;
            end
            "mret"  : mret = 1'b1;
            "idle"  : ;
            default : begin
                $display("Unknown vector kind '%s' on entry %0d", kinds[idx], idx);
                $display("Test failed");
                $fatal(1, "Bad vector");
            end
        endcase
        // Timer and interrupt lines move every cycle
        time_expect = timer_value;
        timer_value = (idx == 0) ? TIME_START : timer_value + TIME_STEP;
        irq_pending = 3'($random(seed));
    endtask

    task automatic check_vector(input int idx);
        logic want_request;
        want_request = mie_bit & (|(mip_value(irq_pending) & mie_reg));
        check_flag("o_illegal", illegal, illegals[idx]);
        if (access)
            check_data($sformatf("csr %h", addrs[idx]), read_data, expected_read(idx));
        check_flag("o_irq_enable", irq_enable, mie_bit);
        check_flag("o_irq_request", irq_request, want_request);
        check_data("o_mepc", mepc, mepc_reg);
        check_data("o_mtvec", mtvec, mtvec_reg);
    endtask

    // State after the next edge
    task automatic update_model(input int idx);
        csr_data_t status;
        if (retire)
            retire_count = retire_count + 64'd1;
        status                   = '0;
        status[MSTATUS_MIE_BIT]  = mie_bit;
        status[MSTATUS_MPIE_BIT] = mpie_bit;
        if (kinds[idx] == "trap") begin
            mpie_bit = mie_bit;
            mie_bit  = 1'b0;
            mepc_reg = extras[idx] & ~32'h3;     // Low two bits cleared
        end
        else if (kinds[idx] == "mret") begin
            mie_bit  = mpie_bit;
            mpie_bit = 1'b1;
        end
        else if (write_enable && !illegals[idx]) begin
            if (addrs[idx] == 12'h300) begin
                status   = merge_write(kinds[idx], status, datas[idx]);
                mie_bit  = status[MSTATUS_MIE_BIT];
                mpie_bit = status[MSTATUS_MPIE_BIT];
            end
            else if (addrs[idx] == 12'h304)
                mie_reg = merge_write(kinds[idx], mie_reg, datas[idx]) & MIE_WRITE_MASK;
            else if (addrs[idx] == 12'h305)
                mtvec_reg = merge_write(kinds[idx], mtvec_reg, datas[idx]) & ~32'h3;
            else if (addrs[idx] == 12'h341)
                mepc_reg = merge_write(kinds[idx], mepc_reg, datas[idx]) & ~32'h3;
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        int          fd;
        string       line;
        string       kind;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_extra;
        logic [31:0] f_expect;
        logic [31:0] f_illegal;
        clock        = 1'b0;
        reset        = 1'b1;
        access       = 1'b0;
        write_enable = 1'b0;
        write_mode   = CSR_WRITE;
        address      = CSR_MSTATUS;
        write_data   = '0;
        trap         = 1'b0;
        mret         = 1'b0;
        trap_pc      = '0;
        trap_cause   = '0;
        irq_pending  = '0;
        retire       = 1'b0;
        timer_value  = '0;

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s", VECTOR_FILE);
            $display("Test failed");
            $fatal(1, "Missing vectors file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines do not yield six fields
            if ($sscanf(line, "%s %h %h %h %h %h", kind, f_addr, f_data, f_extra,
                        f_expect, f_illegal) == 6) begin
                kinds.push_back(kind);
                addrs.push_back(f_addr[11:0]);
                datas.push_back(f_data);
                extras.push_back(f_extra);
                expects.push_back(f_expect);
                illegals.push_back(f_illegal[0]);
            end
        end
        $fclose(fd);
        if (kinds.size() == 0) begin
            $display("No vectors found in %s", VECTOR_FILE);
            $display("Test failed");
            $fatal(1, "Empty vectors file");
        end
        cycle_limit = 4 * kinds.size() + 100;

        repeat (8) @(negedge clock);
        reset = 1'b0;                        // First vector lands in the same cycle
        for (int i = 0; i < kinds.size(); i++) begin
            if (i != 0)
                @(negedge clock);
            apply_vector(i);
            #1;                              // Combinational outputs settle
            check_vector(i);
            update_model(i);
        end

        @(negedge clock);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== dv/csr_unit_vectors.txt ====
# kind address data extra expected illegal (all hex)
# extra is the trap pc on trap lines and the retire flag on the others
# expected data of counter and mip reads is replaced by the testbench model
read 000 00000000 0 00000000 1
read c00 00000000 0 00000000 0
read 300 00000000 1 00001800 0
read 301 00000000 0 40101100 0
read f14 00000000 1 00000003 0
read 304 00000000 0 00000000 0
read 305 00000000 0 00000000 0
read 340 00000000 0 00000000 0
read 341 00000000 0 00000000 0
read 342 00000000 0 00000000 0
# write modes and masks
write 340 12345678 1 00000000 0
set 340 0000f000 0 12345678 0
clear 340 00000078 1 1234f678 0
read 340 00000000 0 1234f600 0
write 304 ffffffff 0 00000000 0
clear 304 00000080 0 00000888 0
read 304 00000000 0 00000808 0
write 305 80000107 0 00000000 0
read 305 00000000 0 80000104 0
write 341 00000103 0 00000000 0
read 341 00000000 0 00000100 0
write 300 ffffffff 1 00001800 0
read 300 00000000 0 00001888 0
read 344 00000000 0 00000000 0
# illegal accesses, then counters
read 7c0 00000000 0 00000000 1
write c00 ffffffff 0 00000000 1
write c02 ffffffff 1 00000000 1
read c00 00000000 0 00000000 0
read c80 00000000 0 00000000 0
read c02 00000000 0 00000000 0
read c01 00000000 1 00000000 0
read c81 00000000 0 00000000 0
# trap entry and return, first with a colliding mepc write
trap 341 0000000b 80000123 00000100 0
read 341 00000000 0 80000120 0
read 342 00000000 0 0000000b 0
read 300 00000000 0 00001880 0
mret 000 00000000 0 00000000 0
read 300 00000000 0 00001888 0
trap 000 00000007 00000206 00000000 0
read 341 00000000 0 00000204 0
read 342 00000000 0 00000007 0
idle 000 00000000 1 00000000 0
read 344 00000000 0 00000000 0
read c02 00000000 0 00000000 0

// ==== logic/csr_access.sv ====
`timescale 1ns/100ps

module csr_access
    import csr_pkg::*;
#(
    parameter csr_data_t MISA_VALUE = MISA_RV32IMU,
    parameter csr_data_t HART_ID    = '0
) (
    // Pipeline access
    input  logic        i_access,
    input  logic        i_write_enable,
    input  csr_op_e     i_write_mode,
    input  csr_addr_e   i_address,
    input  csr_data_t   i_write_data,

    // Current register values
    input  csr_data_t   i_mstatus,
    input  csr_data_t   i_mie,
    input  csr_data_t   i_mip,
    input  csr_data_t   i_mtvec,
    input  csr_data_t   i_mscratch,
    input  csr_data_t   i_mepc,
    input  csr_data_t   i_mcause,
    input  logic [63:0] i_cycle,
    input  logic [63:0] i_time,
    input  logic [63:0] i_instret,

    // Read side
    output csr_data_t   o_read_data,
    output logic        o_illegal,

    // Write strobes towards the register bank
    output logic        o_write_mstatus,
    output logic        o_write_mie,
    output logic        o_write_mtvec,
    output logic        o_write_mscratch,
    output logic        o_write_mepc,
    output logic        o_write_mcause,
    output csr_data_t   o_write_value
);

    logic [11:0] address_bits;   // Raw address for range checks
    logic        decoded;        // Address hits an implemented CSR
    logic        read_only;      // Top two bits set means read-only space
    logic        write_ok;       // Legal write this cycle
    csr_data_t   read_value;

    assign address_bits = i_address;
    assign read_only    = (address_bits[11:10] == 2'b11);

    // ----------------------------------------
    // Read multiplexer
    // ----------------------------------------

    always_comb begin
        decoded    = 1'b1;
        read_value = '0;
        case (i_address)
            CSR_MSTATUS  : read_value = i_mstatus;
            CSR_MISA     : read_value = MISA_VALUE;
            CSR_MIE      : read_value = i_mie;
            CSR_MTVEC    : read_value = i_mtvec;
            CSR_MSCRATCH : read_value = i_mscratch;
            CSR_MEPC     : read_value = i_mepc;
            CSR_MCAUSE   : read_value = i_mcause;
            CSR_MIP      : read_value = i_mip;
            CSR_MHARTID  : read_value = HART_ID;
            CSR_CYCLE    : read_value = i_cycle[31:0];
            CSR_CYCLEH   : read_value = i_cycle[63:32];
            CSR_TIME     : read_value = i_time[31:0];
            CSR_TIMEH    : read_value = i_time[63:32];
            CSR_INSTRET  : read_value = i_instret[31:0];
            CSR_INSTRETH : read_value = i_instret[63:32];
            default      : decoded = 1'b0;       // Unknown CSR, reads as zero
        endcase
    end

    assign o_read_data = read_value;             // Old value, before any write

    // Unknown address or a write into the read-only space
    assign o_illegal = i_access & (~decoded | (i_write_enable & read_only));

    // ----------------------------------------
    // Write merge
    // ----------------------------------------

    always_comb begin
        case (i_write_mode)
            CSR_SET   : o_write_value = read_value | i_write_data;
            CSR_CLEAR : o_write_value = read_value & ~i_write_data;
            default   : o_write_value = i_write_data;   // CSR_WRITE
        endcase
    end

    // ----------------------------------------
    // Write strobes
    // ----------------------------------------

    assign write_ok = i_access & i_write_enable & ~o_illegal;

    always_comb begin
        o_write_mstatus  = 1'b0;
        o_write_mie      = 1'b0;
        o_write_mtvec    = 1'b0;
        o_write_mscratch = 1'b0;
        o_write_mepc     = 1'b0;
        o_write_mcause   = 1'b0;
        if (write_ok) begin
            case (i_address)
                CSR_MSTATUS  : o_write_mstatus  = 1'b1;
                CSR_MIE      : o_write_mie      = 1'b1;
                CSR_MTVEC    : o_write_mtvec    = 1'b1;
                CSR_MSCRATCH : o_write_mscratch = 1'b1;
                CSR_MEPC     : o_write_mepc     = 1'b1;
                CSR_MCAUSE   : o_write_mcause   = 1'b1;
                default      : ;                 // misa and mip drop the write
            endcase
        end
    end

endmodule

// ==== logic/csr_counters.sv ====
`timescale 1ns/100ps

module csr_counters (
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_retire,                // One pulse per retired instruction
    input  logic [63:0] i_time,                  // From the external timer
    output logic [63:0] o_cycle,
    output logic [63:0] o_time,
    output logic [63:0] o_instret
);

    logic [63:0] cycle_q;
    logic [63:0] time_q;
    logic [63:0] instret_q;

    // ----------------------------------------
    // Cycle counter
    // ----------------------------------------

    // Zero in the first cycle out of reset, then one more each edge
    always_ff @(posedge i_clock) begin
        if (i_reset)
            cycle_q <= '0;
        else
            cycle_q <= cycle_q + 64'd1;
    end

    // ----------------------------------------
    // Retired instructions
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset)
            instret_q <= '0;
        else if (i_retire)
            instret_q <= instret_q + 64'd1;
    end

    // ----------------------------------------
    // Time sample
    // ----------------------------------------

    // Both halves come from one sample, so timeh never tears against time
    always_ff @(posedge i_clock) begin
        if (i_reset)
            time_q <= '0;
        else
            time_q <= i_time;                    // One cycle behind the timer
    end

    assign o_cycle   = cycle_q;
    assign o_time    = time_q;
    assign o_instret = instret_q;

endmodule

// ==== logic/csr_machine_regs.sv ====
`timescale 1ns/100ps

module csr_machine_regs
    import csr_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,

    // Write strobes, one-hot
    input  logic        i_write_mstatus,
    input  logic        i_write_mie,
    input  logic        i_write_mtvec,
    input  logic        i_write_mscratch,
    input  logic        i_write_mepc,
    input  logic        i_write_mcause,
    input  csr_data_t   i_write_value,

    // Trap entry and return
    input  logic        i_trap,
    input  logic        i_mret,
    input  csr_data_t   i_trap_pc,
    input  csr_data_t   i_trap_cause,

    input  logic [2:0]  i_irq_pending,           // {ext, timer, soft}

    output csr_data_t   o_mstatus,
    output csr_data_t   o_mie,
    output csr_data_t   o_mip,
    output csr_data_t   o_mtvec,
    output csr_data_t   o_mscratch,
    output csr_data_t   o_mepc,
    output csr_data_t   o_mcause,
    output logic        o_irq_enable,
    output logic        o_irq_request
);

    csr_data_t mstatus_q;                        // Only MIE and MPIE are stored
    csr_data_t mie_q;
    csr_data_t mtvec_q;
    csr_data_t mscratch_q;
    csr_data_t mepc_q;
    csr_data_t mcause_q;

    // ----------------------------------------
    // mstatus
    // ----------------------------------------

    // Trap beats mret, mret beats a CSR write
    always_ff @(posedge i_clock) begin
        if (i_reset)
            mstatus_q <= '0;
        else if (i_trap) begin
            mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;  // Interrupts off in handler
        end
        else if (i_mret) begin
            mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
            mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
        end
        else if (i_write_mstatus)
            mstatus_q <= i_write_value & MSTATUS_WRITE_MASK;
    end

    // MPP is hardwired to machine mode
    assign o_mstatus = mstatus_q | (csr_data_t'(MPP_MACHINE) << MSTATUS_MPP_BIT);

    // ----------------------------------------
    // Other machine registers
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end
        else begin
            if (i_write_mie)
                mie_q <= i_write_value & MIE_WRITE_MASK;
            if (i_write_mtvec)
                mtvec_q <= {i_write_value[31:2], 2'b00};   // Direct mode only
            if (i_write_mscratch)
                mscratch_q <= i_write_value;
            if (i_trap) begin
                mepc_q   <= {i_trap_pc[31:2], 2'b00};     // Trap wins over a write
                mcause_q <= i_trap_cause;
            end
            else begin
                if (i_write_mepc)
                    mepc_q <= {i_write_value[31:2], 2'b00};
                if (i_write_mcause)
                    mcause_q <= i_write_value;
            end
        end
    end

    // Pending bits land on the same positions as their enables in mie
    always_comb begin
        o_mip                = '0;
        o_mip[IRQ_SOFT_BIT]  = i_irq_pending[0];
        o_mip[IRQ_TIMER_BIT] = i_irq_pending[1];
        o_mip[IRQ_EXT_BIT]   = i_irq_pending[2];
    end

    assign o_mie        = mie_q;
    assign o_mtvec      = mtvec_q;
    assign o_mscratch   = mscratch_q;
    assign o_mepc       = mepc_q;
    assign o_mcause     = mcause_q;

    assign o_irq_enable  = mstatus_q[MSTATUS_MIE_BIT];
    assign o_irq_request = o_irq_enable & (|(o_mip & mie_q));  // Enabled and pending

endmodule

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    // ----------------------------------------
    // Data and address types
    // ----------------------------------------

    typedef logic [31:0] csr_data_t;              // One CSR word

    // Implemented CSR addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MIP      = 12'h344,
        CSR_MHARTID  = 12'hF14,                   // Read-only machine info
        CSR_CYCLE    = 12'hC00,                   // User counters, low halves
        CSR_TIME     = 12'hC01,
        CSR_INSTRET  = 12'hC02,
        CSR_CYCLEH   = 12'hC80,                   // Same counters, high halves
        CSR_TIMEH    = 12'hC81,
        CSR_INSTRETH = 12'hC82
    } csr_addr_e;

    // Write mode, same encoding as funct3[1:0] of CSRRW/CSRRS/CSRRC
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    // ----------------------------------------
    // Bit positions
    // ----------------------------------------

    localparam int MSTATUS_MIE_BIT  = 3;          // Global machine interrupt enable
    localparam int MSTATUS_MPIE_BIT = 7;          // MIE saved at trap entry
    localparam int MSTATUS_MPP_BIT  = 11;         // LSB of the 2-bit MPP field

    // Shared by mie and mip
    localparam int IRQ_SOFT_BIT  = 3;
    localparam int IRQ_TIMER_BIT = 7;
    localparam int IRQ_EXT_BIT   = 11;

    // Only machine mode is ever entered by a trap
    localparam logic [1:0] MPP_MACHINE = 2'b11;

    // ----------------------------------------
    // Write masks
    // ----------------------------------------

    // MIE and MPIE are the only writable mstatus bits
    localparam csr_data_t MSTATUS_WRITE_MASK =
        (32'h1 << MSTATUS_MIE_BIT) |
        (32'h1 << MSTATUS_MPIE_BIT);

    // Machine soft, timer and external enables
    localparam csr_data_t MIE_WRITE_MASK =
        (32'h1 << IRQ_SOFT_BIT)  |
        (32'h1 << IRQ_TIMER_BIT) |
        (32'h1 << IRQ_EXT_BIT);

    // RV32I base with M and U extensions
    localparam csr_data_t MISA_RV32IMU =
        (32'h1 <<  8) |                           // I - base integer ISA
        (32'h1 << 12) |                           // M - multiply/divide
        (32'h1 << 20) |                           // U - user mode
        (32'h1 << 30);                            // MXL = 1, 32-bit

endpackage

// ==== logic/csr_unit.sv ====
`timescale 1ns/100ps

module csr_unit
    import csr_pkg::*;
#(
    parameter csr_data_t MISA_VALUE = MISA_RV32IMU,
    parameter csr_data_t HART_ID    = '0
) (
    input  logic        i_clock,
    input  logic        i_reset,

    // CSR instruction access
    input  logic        i_access,
    input  logic        i_write_enable,
    input  csr_op_e     i_write_mode,
    input  csr_addr_e   i_address,
    input  csr_data_t   i_write_data,

    // Trap entry and return
    input  logic        i_trap,
    input  logic        i_mret,
    input  csr_data_t   i_trap_pc,
    input  csr_data_t   i_trap_cause,

    // Status from the rest of the core
    input  logic [2:0]  i_irq_pending,
    input  logic        i_retire,
    input  logic [63:0] i_time,

    output csr_data_t   o_read_data,
    output logic        o_illegal,
    output csr_data_t   o_mepc,                  // Return target for mret
    output csr_data_t   o_mtvec,                 // Trap handler base
    output logic        o_irq_enable,
    output logic        o_irq_request
);

    // Register values back to the decoder
    csr_data_t   mstatus;
    csr_data_t   mie;
    csr_data_t   mip;
    csr_data_t   mscratch;
    csr_data_t   mcause;
    logic [63:0] cycle;
    logic [63:0] time_value;
    logic [63:0] instret;

    // Decoder to register bank
    logic        write_mstatus;
    logic        write_mie;
    logic        write_mtvec;
    logic        write_mscratch;
    logic        write_mepc;
    logic        write_mcause;
    csr_data_t   write_value;

    // ----------------------------------------
    // Access decoder
    // ----------------------------------------

    csr_access #(
        .MISA_VALUE (MISA_VALUE),
        .HART_ID    (HART_ID)
    ) access (
        .i_access         (i_access),
        .i_write_enable   (i_write_enable),
        .i_write_mode     (i_write_mode),
        .i_address        (i_address),
        .i_write_data     (i_write_data),
        .i_mstatus        (mstatus),
        .i_mie            (mie),
        .i_mip            (mip),
        .i_mtvec          (o_mtvec),
        .i_mscratch       (mscratch),
        .i_mepc           (o_mepc),
        .i_mcause         (mcause),
        .i_cycle          (cycle),
        .i_time           (time_value),
        .i_instret        (instret),
        .o_read_data      (o_read_data),
        .o_illegal        (o_illegal),
        .o_write_mstatus  (write_mstatus),
        .o_write_mie      (write_mie),
        .o_write_mtvec    (write_mtvec),
        .o_write_mscratch (write_mscratch),
        .o_write_mepc     (write_mepc),
        .o_write_mcause   (write_mcause),
        .o_write_value    (write_value)
    );

    // ----------------------------------------
    // Machine trap registers
    // ----------------------------------------

    csr_machine_regs regs (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_write_mstatus  (write_mstatus),
        .i_write_mie      (write_mie),
        .i_write_mtvec    (write_mtvec),
        .i_write_mscratch (write_mscratch),
        .i_write_mepc     (write_mepc),
        .i_write_mcause   (write_mcause),
        .i_write_value    (write_value),
        .i_trap           (i_trap),
        .i_mret           (i_mret),
        .i_trap_pc        (i_trap_pc),
        .i_trap_cause     (i_trap_cause),
        .i_irq_pending    (i_irq_pending),
        .o_mstatus        (mstatus),
        .o_mie            (mie),
        .o_mip            (mip),
        .o_mtvec          (o_mtvec),
        .o_mscratch       (mscratch),
        .o_mepc           (o_mepc),
        .o_mcause         (mcause),
        .o_irq_enable     (o_irq_enable),
        .o_irq_request    (o_irq_request)
    );

    // ----------------------------------------
    // Counters
    // ----------------------------------------

    csr_counters counters (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_retire  (i_retire),
        .i_time    (i_time),
        .o_cycle   (cycle),
        .o_time    (time_value),
        .o_instret (instret)
    );

endmodule

// ==== tb.f ====
logic/csr_pkg.sv
logic/csr_access.sv
logic/csr_machine_regs.sv
logic/csr_counters.sv
logic/csr_unit.sv
dv/csr_unit_assertions.sv
dv/csr_unit_tb.sv
